// File: tb.f
hw/srm_pkg.sv
hw/srm_ctrl_if.sv
hw/srm_controller.sv
hw/srm_decoder.sv
hw/srm_regfile.sv
hw/srm_datapath.sv
hw/srm_fetch_unit.sv
hw/srm_top.sv
bench/srm_tb.sv

// File: run.sh
#!/bin/sh
# build and run the srm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module srm_tb -o srm_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/srm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q '\*\*\* TEST PASSED \*\*\*'; then
    exit 0
fi
exit 1

// File: bench/srm_tb.sv
`timescale 1ns/1ps

module srm_tb;

    localparam srm_pkg::data_t reset_pc = 16'h0010;
    localparam int max_instr   = 40;
    localparam int num_tests   = 6;
    localparam int cycle_limit = 40 * max_instr * num_tests;

    logic              clk;
    logic              reset;
    srm_pkg::data_t    read_data;
    srm_pkg::mem_cmd_e mem_cmd;
    srm_pkg::data_t    mem_addr;
    srm_pkg::data_t    write_data;
    logic              halted;

    logic [15:0] mem [256];
    logic [15:0] ref_mem [256];
    logic [15:0] ref_reg [8];
    logic [15:0] prog [$];
    logic [15:0] exp_addr_q [$];
    logic [15:0] exp_data_q [$];
    logic        ref_halted;
    logic        first_read;
    int          errors;
    int          cycles;
    int          seed;
    int          tests_passed;
    int          tests_failed;
    string       current_test;

    srm_top #(.reset_pc(reset_pc)) dut_i (
        .clk        (clk),
        .reset      (reset),
        .read_data  (read_data),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .halted     (halted)
    );

    assign read_data = mem[mem_addr[7:0]]; // combinational read

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [15:0] enc_alu(input logic [2:0] opc, input logic [1:0] op,
                                            input logic [2:0] rn, input logic [2:0] rd,
                                            input logic [1:0] sh, input logic [2:0] rm);
        return {opc, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [15:0] enc_mov_imm(input logic [2:0] rn, input logic [7:0] imm);
        return {srm_pkg::opc_mov, srm_pkg::op_mov_imm, rn, imm};
    endfunction

    function automatic logic [15:0] enc_mem(input logic [2:0] opc, input logic [2:0] rn,
                                            input logic [2:0] rd, input logic [4:0] off);
        return {opc, 2'b00, rn, rd, off};
    endfunction

    function automatic logic [15:0] enc_branch(input logic [2:0] cond, input logic [7:0] off);
        return {srm_pkg::opc_b, 2'b00, cond, off};
    endfunction

    function automatic logic [15:0] shifted(input logic [15:0] val, input logic [1:0] sh);
        case (sh)
            2'd1: return {val[14:0], 1'b0};
            2'd2: return {1'b0, val[15:1]};
            2'd3: return {val[15], val[15:1]};
            default: return val;
        endcase
    endfunction

    // instruction-level model of the program in ref_mem
    function automatic void ref_run();
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] b;
        logic [15:0] r;
        logic [15:0] addr;
        logic        z;
        logic        n;
        logic        v;
        logic        take;
        int          steps;
        pc = reset_pc;
        z = 1'b0;
        n = 1'b0;
        v = 1'b0;
        ref_halted = 1'b0;
        for (int i = 0; i < 8; i++) begin
            ref_reg[i] = 16'h0000;
        end
        for (steps = 0; steps < 1000 && !ref_halted; steps++) begin
            ir = ref_mem[pc[7:0]];
            pc = pc + 16'd1;
            b = shifted(ref_reg[ir[2:0]], ir[4:3]);
            addr = ref_reg[ir[10:8]] + {{11{ir[4]}}, ir[4:0]};
            case (ir[15:13])
                srm_pkg::opc_mov: begin
                    if (ir[12:11] == srm_pkg::op_mov_imm) begin
                        ref_reg[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
                    end else begin
                        ref_reg[ir[7:5]] = b;
                    end
                end
                srm_pkg::opc_alu: begin
                    case (ir[12:11])
                        srm_pkg::op_add: ref_reg[ir[7:5]] = ref_reg[ir[10:8]] + b;
                        srm_pkg::op_and: ref_reg[ir[7:5]] = ref_reg[ir[10:8]] & b;
                        srm_pkg::op_mvn: ref_reg[ir[7:5]] = ~b;
                        default: begin // cmp
                            r = ref_reg[ir[10:8]] - b;
                            z = (r == 16'h0000);
                            n = r[15];
                            v = (ref_reg[ir[10:8]][15] != b[15]) && (r[15] != b[15] ^ 1'b1);
                        end
                    endcase
                end
                srm_pkg::opc_ldr: ref_reg[ir[7:5]] = ref_mem[addr[7:0]];
                srm_pkg::opc_str: begin
                    ref_mem[addr[7:0]] = ref_reg[ir[7:5]];
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(ref_reg[ir[7:5]]);
                end
                srm_pkg::opc_b: begin
                    case (ir[10:8])
                        srm_pkg::cond_al: take = 1'b1;
                        srm_pkg::cond_eq: take = z;
                        srm_pkg::cond_ne: take = ~z;
                        srm_pkg::cond_lt: take = n ^ v;
                        srm_pkg::cond_le: take = z | (n ^ v);
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        pc = pc + {{8{ir[7]}}, ir[7:0]};
                    end
                end
                default: ref_halted = 1'b1;
            endcase
        end
    endfunction

    // checks the first fetch address and every store
    always @(posedge clk) begin
        if (reset) begin
            first_read = 1'b0;
        end else begin
            if (mem_cmd == srm_pkg::mem_read && !first_read) begin
                first_read = 1'b1;
                check_value("mem_addr", mem_addr, reset_pc);
            end
            if (mem_cmd == srm_pkg::mem_write) begin
                if (!first_read) begin
                    $display("write command seen before the first fetch at %0t", $time);
                    errors++;
                end
                mem[mem_addr[7:0]] = write_data;
                if (exp_addr_q.size() == 0) begin
                    $display("unexpected store to %h at %0t", mem_addr, $time);
                    errors++;
                end else begin
                    check_value("mem_addr", mem_addr, exp_addr_q.pop_front());
                    check_value("write_data", write_data, exp_data_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles in %s, halted never rose", cycles, current_test);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic clear_memory();
        logic [7:0] a8;
        for (int a = 0; a < 256; a++) begin
            a8 = a[7:0];
            mem[a8] = {a8, ~a8} ^ 16'h3c5a;
        end
        prog.delete();
    endtask

    task automatic run_test(input string name);
        int          errs_start;
        logic [15:0] pa;
        errs_start = errors;
        current_test = name;
        for (int i = 0; i < prog.size(); i++) begin
            pa = reset_pc + i[15:0];
            mem[pa[7:0]] = prog[i];
        end
        for (int a = 0; a < 256; a++) begin
            ref_mem[a[7:0]] = mem[a[7:0]];
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        ref_run();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        check_value("halted", {15'b0, halted}, 16'h0000);
        check_value("mem_cmd", {14'b0, mem_cmd}, {14'b0, srm_pkg::mem_none});
        reset <= 1'b0;
        while (halted !== 1'b1) @(posedge clk);
        repeat (20) begin
            @(posedge clk);
            check_value("mem_cmd", {14'b0, mem_cmd}, {14'b0, srm_pkg::mem_none});
            check_value("halted", {15'b0, halted}, 16'h0001);
        end
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected stores never happened", exp_addr_q.size());
            errors++;
        end
        if (!ref_halted) begin
            $display("reference model never reached HALT");
            errors++;
        end
        if (errors == errs_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_start);
        end
    endtask

    // five CMP and branch blocks that each store a taken or not-taken marker
    task automatic build_branch_prog(input logic [15:0] x, input logic [15:0] y);
        logic [2:0] c;
        clear_memory();
        mem[8'h78] = x; // full 16-bit operands
        mem[8'h79] = y;
        prog.push_back(enc_mov_imm(3'd0, 8'h70));
        prog.push_back(enc_mem(srm_pkg::opc_ldr, 3'd0, 3'd1, 5'd8));
        prog.push_back(enc_mem(srm_pkg::opc_ldr, 3'd0, 3'd2, 5'd9));
        for (int k = 0; k < 5; k++) begin
            c = k[2:0];
            prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_cmp, 3'd1, 3'd0, 2'd0, 3'd2));
            prog.push_back(enc_branch(c, 8'd2));
            prog.push_back(enc_mov_imm(3'd3, {5'b00010, c}));
            prog.push_back(enc_branch(srm_pkg::cond_al, 8'd1));
            prog.push_back(enc_mov_imm(3'd3, {5'b00100, c}));
            prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd3, {2'b00, c}));
        end
        prog.push_back({srm_pkg::opc_halt, 13'b0});
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [1:0]  sh;
        reset = 1'b1;
        errors = 0;
        cycles = 0;
        tests_passed = 0;
        tests_failed = 0;
        first_read = 1'b0;
        seed = 32'h9302349c;
        clear_memory();

        r = $random(seed);
        x = r[7:0];
        sh = r[9:8];
        prog.push_back(enc_mov_imm(3'd0, 8'h40));
        prog.push_back(enc_mov_imm(3'd1, x));
        prog.push_back(enc_alu(srm_pkg::opc_mov, srm_pkg::op_mov_reg, 3'd0, 3'd2, sh, 3'd1));
        prog.push_back(enc_alu(srm_pkg::opc_mov, srm_pkg::op_mov_reg, 3'd0, 3'd3, 2'd1, 3'd2));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd1, 5'd0));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd2, 5'd1));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd3, 5'h1f));
        prog.push_back({srm_pkg::opc_halt, 13'b0});
        run_test("mov");

        clear_memory();
        r = $random(seed);
        x = r[7:0];
        y = r[15:8];
        prog.push_back(enc_mov_imm(3'd0, 8'h50));
        prog.push_back(enc_mov_imm(3'd1, x));
        prog.push_back(enc_mov_imm(3'd2, y));
        for (int k = 0; k < 4; k++) begin
            sh = k[1:0];
            prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_add, 3'd1, 3'd3, sh, 3'd2));
            prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_and, 3'd1, 3'd4, sh, 3'd2));
            prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_mvn, 3'd0, 3'd5, sh, 3'd2));
            prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd3, 5'(k * 3)));
            prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd4, 5'(k * 3 + 1)));
            prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd5, 5'(k * 3 + 2)));
        end
        prog.push_back({srm_pkg::opc_halt, 13'b0});
        run_test("alu_shift");

        clear_memory();
        r = $random(seed);
        mem[8'h60] = r[15:0];
        mem[8'h61] = r[31:16];
        prog.push_back(enc_mov_imm(3'd0, 8'h60));
        prog.push_back(enc_mem(srm_pkg::opc_ldr, 3'd0, 3'd1, 5'd0));
        prog.push_back(enc_mem(srm_pkg::opc_ldr, 3'd0, 3'd2, 5'd1));
        prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_add, 3'd1, 3'd3, 2'd3, 3'd2));
        prog.push_back(enc_alu(srm_pkg::opc_alu, srm_pkg::op_mvn, 3'd0, 3'd4, 2'd0, 3'd1));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd3, 5'h1e));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd4, 5'd4));
        prog.push_back(enc_mem(srm_pkg::opc_str, 3'd0, 3'd2, 5'd5));
        prog.push_back({srm_pkg::opc_halt, 13'b0});
        run_test("ldr");

        r = $random(seed);
        build_branch_prog(r[15:0], r[31:16]);
        run_test("branch_random");
        build_branch_prog(r[15:0], r[15:0]);
        run_test("branch_equal");
        build_branch_prog(16'h8000, 16'h0001); // most negative minus one overflows
        run_test("branch_less");

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: hw/srm_top.sv
`timescale 1ns/1ps

module srm_top #(
    parameter srm_pkg::data_t reset_pc = 16'h0000
) (
    input  logic              clk,
    input  logic              reset,
    input  srm_pkg::data_t    read_data,
    output srm_pkg::mem_cmd_e mem_cmd,
    output srm_pkg::data_t    mem_addr,
    output srm_pkg::data_t    write_data,
    output logic              halted
);

    srm_pkg::opcode_e  opcode;
    srm_pkg::op_e      op;
    srm_pkg::cond_e    cond;
    srm_pkg::reg_num_t reg_num;
    srm_pkg::shift_e   shift;
    srm_pkg::data_t    sximm8;
    srm_pkg::data_t    sximm5;
    srm_pkg::data_t    c_out;
    logic              z;
    logic              v;
    logic              n;

    srm_ctrl_if ctrl_i ();

    srm_controller controller_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .op     (op),
        .cond   (cond),
        .z      (z),
        .v      (v),
        .n      (n),
        .ctrl   (ctrl_i.controller),
        .halted (halted)
    );

    srm_decoder decoder_i (
        .clk       (clk),
        .ctrl      (ctrl_i.decoder),
        .read_data (read_data),
        .opcode    (opcode),
        .op        (op),
        .cond      (cond),
        .reg_num   (reg_num),
        .shift     (shift),
        .sximm8    (sximm8),
        .sximm5    (sximm5)
    );

    srm_datapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl_i.datapath),
        .reg_num   (reg_num),
        .shift     (shift),
        .sximm8    (sximm8),
        .sximm5    (sximm5),
        .read_data (read_data),
        .c_out     (c_out),
        .z         (z),
        .v         (v),
        .n         (n)
    );

    srm_fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_i (
        .clk      (clk),
        .ctrl     (ctrl_i.fetch),
        .sximm8   (sximm8),
        .c_out    (c_out),
        .mem_addr (mem_addr)
    );

    assign mem_cmd    = ctrl_i.mem_cmd;
    assign write_data = c_out; // C holds Rd during the store write

endmodule

// File: hw/srm_fetch_unit.sv
`timescale 1ns/1ps

module srm_fetch_unit #(
    parameter srm_pkg::data_t reset_pc = 16'h0000
) (
    input  logic           clk,
    srm_ctrl_if.fetch      ctrl,
    input  srm_pkg::data_t sximm8,
    input  srm_pkg::data_t c_out,
    output srm_pkg::data_t mem_addr
);

    srm_pkg::data_t pc;
    srm_pkg::data_t data_addr;

    // pc is loaded with reset_pc in the RST state
    always_ff @(posedge clk) begin
        if (ctrl.load_pc) begin
            case (ctrl.pcsel)
                srm_pkg::pcsel_plus1: pc <= pc + 16'd1;
                srm_pkg::pcsel_branch: pc <= pc + sximm8; // pc already points past the branch
                default: pc <= reset_pc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_addr) begin
            data_addr <= c_out;
        end
    end

    assign mem_addr = ctrl.addr_sel ? pc : data_addr;

endmodule

// File: hw/srm_datapath.sv
`timescale 1ns/1ps

module srm_datapath (
    input  logic              clk,
    input  logic              reset,
    srm_ctrl_if.datapath      ctrl,
    input  srm_pkg::reg_num_t reg_num,
    input  srm_pkg::shift_e   shift,
    input  srm_pkg::data_t    sximm8,
    input  srm_pkg::data_t    sximm5,
    input  srm_pkg::data_t    read_data,
    output srm_pkg::data_t    c_out,
    output logic              z,
    output logic              v,
    output logic              n
);

    srm_pkg::data_t wb_data;
    srm_pkg::data_t reg_out;
    srm_pkg::data_t a_q;
    srm_pkg::data_t b_q;
    srm_pkg::data_t b_shift;
    srm_pkg::data_t ain;
    srm_pkg::data_t bin;
    srm_pkg::data_t alu_out;
    logic           alu_v;

    always_comb begin
        case (ctrl.vsel)
            srm_pkg::vsel_imm: wb_data = sximm8;
            srm_pkg::vsel_mdata: wb_data = read_data;
            default: wb_data = c_out;
        endcase
    end

    srm_regfile regfile_i (
        .clk      (clk),
        .write    (ctrl.write),
        .num      (reg_num),
        .data_in  (wb_data),
        .data_out (reg_out)
    );

    always_ff @(posedge clk) begin
        if (ctrl.loada) begin
            a_q <= reg_out;
        end
        if (ctrl.loadb) begin
            b_q <= reg_out;
        end
        if (ctrl.loadc) begin
            c_out <= alu_out;
        end
    end

    always_comb begin
        case (shift)
            srm_pkg::sh_left: b_shift = {b_q[14:0], 1'b0};
            srm_pkg::sh_right: b_shift = {1'b0, b_q[15:1]};
            srm_pkg::sh_arith: b_shift = {b_q[15], b_q[15:1]};
            default: b_shift = b_q;
        endcase
    end

    assign ain = ctrl.asel ? 16'h0000 : a_q;
    assign bin = ctrl.bsel ? sximm5 : b_shift;

    always_comb begin
        alu_v = 1'b0;
        case (ctrl.alu_op)
            srm_pkg::op_add: alu_out = ain + bin;
            srm_pkg::op_cmp: begin
                alu_out = ain - bin;
                alu_v   = (ain[15] != bin[15]) && (alu_out[15] != ain[15]);
            end
            srm_pkg::op_and: alu_out = ain & bin;
            default: alu_out = ~bin;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            z <= 1'b0;
            v <= 1'b0;
            n <= 1'b0;
        end else if (ctrl.loads) begin
            z <= (alu_out == 16'h0000);
            v <= alu_v;
            n <= alu_out[15];
        end
    end

endmodule

// File: hw/srm_regfile.sv
`timescale 1ns/1ps

module srm_regfile (
    input  logic              clk,
    input  logic              write,
    input  srm_pkg::reg_num_t num,
    input  srm_pkg::data_t    data_in,
    output srm_pkg::data_t    data_out
);

    srm_pkg::data_t regs [8];

    always_ff @(posedge clk) begin
        if (write) begin
            regs[num] <= data_in;
        end
    end

    assign data_out = regs[num]; // same number as the write

endmodule

// File: hw/srm_decoder.sv
`timescale 1ns/1ps

module srm_decoder (
    input  logic              clk,
    srm_ctrl_if.decoder       ctrl,
    input  srm_pkg::data_t    read_data,
    output srm_pkg::opcode_e  opcode,
    output srm_pkg::op_e      op,
    output srm_pkg::cond_e    cond,
    output srm_pkg::reg_num_t reg_num,
    output srm_pkg::shift_e   shift,
    output srm_pkg::data_t    sximm8,
    output srm_pkg::data_t    sximm5
);

    srm_pkg::instr_u ir;
    logic            shift_used;

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) begin
            ir <= read_data;
        end
    end

    assign opcode = ir.alu.opcode;
    assign op     = ir.alu.op;
    assign cond   = ir.branch.cond;

    // low byte is the MOV immediate as well as the branch offset
    assign sximm8 = {{8{ir.branch.offset[7]}}, ir.branch.offset};
    assign sximm5 = {{11{ir.imm.offset[4]}}, ir.imm.offset};

    // shift bits overlap the memory offset
    assign shift_used = (ir.alu.opcode == srm_pkg::opc_alu) ||
                        (ir.alu.opcode == srm_pkg::opc_mov && ir.alu.op == srm_pkg::op_mov_reg);
    assign shift = shift_used ? ir.alu.shift : srm_pkg::sh_none;

    always_comb begin
        case (ctrl.nsel)
            srm_pkg::nsel_rd: reg_num = ir.alu.rd;
            srm_pkg::nsel_rm: reg_num = ir.alu.rm;
            default: reg_num = ir.alu.rn;
        endcase
    end

endmodule

// File: hw/srm_controller.sv
`timescale 1ns/1ps

module srm_controller (
    input  logic             clk,
    input  logic             reset,
    input  srm_pkg::opcode_e opcode,
    input  srm_pkg::op_e     op,
    input  srm_pkg::cond_e   cond,
    input  logic             z,
    input  logic             v,
    input  logic             n,
    srm_ctrl_if.controller   ctrl,
    output logic            halted
);

    srm_pkg::state_e state;
    logic            take_branch;

    always_comb begin
        case (cond)
            srm_pkg::cond_al: take_branch = 1'b1;
            srm_pkg::cond_eq: take_branch = z;
            srm_pkg::cond_ne: take_branch = ~z;
            srm_pkg::cond_lt: take_branch = n ^ v;
            srm_pkg::cond_le: take_branch = z | (n ^ v);
            default: take_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= srm_pkg::s_rst;
        end else begin
            case (state)
                srm_pkg::s_rst: state <= srm_pkg::s_if1;
                srm_pkg::s_if1: state <= srm_pkg::s_if2;
                srm_pkg::s_if2: state <= srm_pkg::s_update_pc;
                srm_pkg::s_update_pc: state <= srm_pkg::s_decode;
                srm_pkg::s_decode: begin
                    case (opcode)
                        srm_pkg::opc_mov: begin
                            if (op == srm_pkg::op_mov_imm) begin
                                state <= srm_pkg::s_write_imm;
                            end else begin
                                state <= srm_pkg::s_wr0;
                            end
                        end
                        srm_pkg::opc_alu: begin
                            case (op)
                                srm_pkg::op_add: state <= srm_pkg::s_add0;
                                srm_pkg::op_cmp: state <= srm_pkg::s_cmp0;
                                srm_pkg::op_and: state <= srm_pkg::s_and0;
                                default: state <= srm_pkg::s_mvn0;
                            endcase
                        end
                        srm_pkg::opc_ldr: state <= srm_pkg::s_ldr0;
                        srm_pkg::opc_str: state <= srm_pkg::s_str0;
                        srm_pkg::opc_b: state <= srm_pkg::s_b1;
                        default: state <= srm_pkg::s_halt; // halt and undefined opcodes
                    endcase
                end
                srm_pkg::s_wr0: state <= srm_pkg::s_wr1;
                srm_pkg::s_wr1: state <= srm_pkg::s_wr2;
                srm_pkg::s_add0: state <= srm_pkg::s_add1;
                srm_pkg::s_add1: state <= srm_pkg::s_add2;
                srm_pkg::s_add2: state <= srm_pkg::s_add3;
                srm_pkg::s_cmp0: state <= srm_pkg::s_cmp1;
                srm_pkg::s_cmp1: state <= srm_pkg::s_cmp2;
                srm_pkg::s_and0: state <= srm_pkg::s_and1;
                srm_pkg::s_and1: state <= srm_pkg::s_and2;
                srm_pkg::s_and2: state <= srm_pkg::s_and3;
                srm_pkg::s_mvn0: state <= srm_pkg::s_mvn1;
                srm_pkg::s_mvn1: state <= srm_pkg::s_mvn2;
                srm_pkg::s_ldr0: state <= srm_pkg::s_ldr1;
                srm_pkg::s_ldr1: state <= srm_pkg::s_ldr2;
                srm_pkg::s_ldr2: state <= srm_pkg::s_ldr3;
                srm_pkg::s_ldr3: state <= srm_pkg::s_ldr4;
                srm_pkg::s_str0: state <= srm_pkg::s_str1;
                srm_pkg::s_str1: state <= srm_pkg::s_str2;
                srm_pkg::s_str2: state <= srm_pkg::s_str3;
                srm_pkg::s_str3: state <= srm_pkg::s_str4;
                srm_pkg::s_str4: state <= srm_pkg::s_str5;
                srm_pkg::s_halt: state <= srm_pkg::s_halt; // only reset leaves
                srm_pkg::s_b1: state <= srm_pkg::s_b2;
                srm_pkg::s_b2: state <= take_branch ? srm_pkg::s_goto : srm_pkg::s_if1;
                default: state <= srm_pkg::s_if1; // last state of every instruction
            endcase
        end
    end

    always_comb begin
        ctrl.nsel      = srm_pkg::nsel_rn;
        ctrl.vsel      = srm_pkg::vsel_c;
        ctrl.write     = 1'b0;
        ctrl.loada     = 1'b0;
        ctrl.loadb     = 1'b0;
        ctrl.asel      = 1'b0;
        ctrl.bsel      = 1'b0;
        ctrl.alu_op    = srm_pkg::op_add;
        ctrl.loadc     = 1'b0;
        ctrl.loads     = 1'b0;
        ctrl.load_ir   = 1'b0;
        ctrl.load_pc   = 1'b0;
        ctrl.pcsel     = srm_pkg::pcsel_reset;
        ctrl.addr_sel  = 1'b1;
        ctrl.load_addr = 1'b0;
        ctrl.mem_cmd   = srm_pkg::mem_none;
        case (state)
            srm_pkg::s_rst: ctrl.load_pc = 1'b1;
            srm_pkg::s_if1: ctrl.mem_cmd = srm_pkg::mem_read;
            srm_pkg::s_if2: begin
                ctrl.mem_cmd = srm_pkg::mem_read;
                ctrl.load_ir = 1'b1;
            end
            srm_pkg::s_update_pc: begin
                ctrl.pcsel   = srm_pkg::pcsel_plus1;
                ctrl.load_pc = 1'b1;
            end
            srm_pkg::s_write_imm: begin // MOV imm writes Rn
                ctrl.vsel  = srm_pkg::vsel_imm;
                ctrl.write = 1'b1;
            end
            srm_pkg::s_add0, srm_pkg::s_cmp0, srm_pkg::s_and0,
            srm_pkg::s_ldr0, srm_pkg::s_str0: ctrl.loada = 1'b1;
            srm_pkg::s_wr0, srm_pkg::s_add1, srm_pkg::s_cmp1,
            srm_pkg::s_and1, srm_pkg::s_mvn0: begin
                ctrl.nsel  = srm_pkg::nsel_rm;
                ctrl.loadb = 1'b1;
            end
            srm_pkg::s_wr1, srm_pkg::s_str4: begin // 0 + b
                ctrl.asel  = 1'b1;
                ctrl.loadc = 1'b1;
            end
            srm_pkg::s_add2: ctrl.loadc = 1'b1;
            srm_pkg::s_and2: begin
                ctrl.alu_op = srm_pkg::op_and;
                ctrl.loadc  = 1'b1;
            end
            srm_pkg::s_mvn1: begin
                ctrl.alu_op = srm_pkg::op_mvn;
                ctrl.loadc  = 1'b1;
            end
            srm_pkg::s_cmp2: begin
                ctrl.alu_op = srm_pkg::op_cmp;
                ctrl.loads  = 1'b1;
            end
            srm_pkg::s_wr2, srm_pkg::s_add3, srm_pkg::s_and3, srm_pkg::s_mvn2: begin
                ctrl.nsel  = srm_pkg::nsel_rd;
                ctrl.write = 1'b1;
            end
            srm_pkg::s_ldr1, srm_pkg::s_str1: begin // base + sximm5
                ctrl.bsel  = 1'b1;
                ctrl.loadc = 1'b1;
            end
            srm_pkg::s_ldr2, srm_pkg::s_str2: ctrl.load_addr = 1'b1;
            srm_pkg::s_ldr3: begin
                ctrl.mem_cmd  = srm_pkg::mem_read;
                ctrl.addr_sel = 1'b0;
            end
            srm_pkg::s_ldr4: begin
                ctrl.mem_cmd  = srm_pkg::mem_read;
                ctrl.addr_sel = 1'b0;
                ctrl.nsel     = srm_pkg::nsel_rd;
                ctrl.vsel     = srm_pkg::vsel_mdata;
                ctrl.write    = 1'b1;
            end
            srm_pkg::s_str3: begin
                ctrl.nsel  = srm_pkg::nsel_rd;
                ctrl.loadb = 1'b1;
            end
            srm_pkg::s_str5: begin
                ctrl.mem_cmd  = srm_pkg::mem_write;
                ctrl.addr_sel = 1'b0;
            end
            srm_pkg::s_goto: begin
                ctrl.pcsel   = srm_pkg::pcsel_branch;
                ctrl.load_pc = 1'b1;
            end
            default: ctrl.load_pc = 1'b0;
        endcase
    end

    assign halted = (state == srm_pkg::s_halt);

endmodule

// File: hw/srm_ctrl_if.sv
`timescale 1ns/1ps

interface srm_ctrl_if;
    srm_pkg::nsel_e    nsel;
    srm_pkg::vsel_e    vsel;
    logic              write;
    logic              loada;
    logic              loadb;
    logic              asel;      // high puts zero on the A side of the ALU
    logic              bsel;      // high puts sximm5 on the B side
    srm_pkg::op_e      alu_op;
    logic              loadc;
    logic              loads;
    logic              load_ir;
    logic              load_pc;
    srm_pkg::pcsel_e   pcsel;
    logic              addr_sel;  // selects pc when high and the data address when low
    logic              load_addr;
    srm_pkg::mem_cmd_e mem_cmd;

    modport controller (
        output nsel, vsel, write, loada, loadb, asel, bsel, alu_op,
        output loadc, loads, load_ir, load_pc, pcsel, addr_sel, load_addr, mem_cmd
    );

    modport decoder (input nsel, load_ir);

    modport datapath (input vsel, write, loada, loadb, asel, bsel, alu_op, loadc, loads);

    modport fetch (input pcsel, load_pc, addr_sel, load_addr);

endinterface

// File: hw/srm_pkg.sv
package srm_pkg;

    typedef logic [15:0] data_t;
    typedef logic [2:0]  reg_num_t;

    typedef enum logic [2:0] {
        opc_b    = 3'b001,
        opc_ldr  = 3'b011,
        opc_str  = 3'b100,
        opc_alu  = 3'b101,
        opc_mov  = 3'b110,
        opc_halt = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_cmp = 2'b01, // subtract that only sets the flags
        op_and = 2'b10,
        op_mvn = 2'b11
    } op_e;

    // same field under the MOV opcode
    localparam op_e op_mov_reg = op_add;
    localparam op_e op_mov_imm = op_and;

    typedef enum logic [1:0] {sh_none, sh_left, sh_right, sh_arith} shift_e;

    typedef enum logic [2:0] {cond_al, cond_eq, cond_ne, cond_lt, cond_le} cond_e;

    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_cmd_e;

    typedef enum logic [1:0] {nsel_rn, nsel_rd, nsel_rm} nsel_e;

    typedef enum logic [1:0] {vsel_c, vsel_imm, vsel_mdata} vsel_e;

    typedef enum logic [1:0] {pcsel_reset, pcsel_plus1, pcsel_branch} pcsel_e;

    typedef enum logic [5:0] {
        s_rst, s_if1, s_if2, s_update_pc, s_decode,
        s_write_imm,
        s_wr0, s_wr1, s_wr2,
        s_add0, s_add1, s_add2, s_add3,
        s_cmp0, s_cmp1, s_cmp2,
        s_and0, s_and1, s_and2, s_and3,
        s_mvn0, s_mvn1, s_mvn2,
        s_ldr0, s_ldr1, s_ldr2, s_ldr3, s_ldr4,
        s_str0, s_str1, s_str2, s_str3, s_str4, s_str5,
        s_halt,
        s_b1, s_b2, s_goto
    } state_e;

    typedef struct packed {
        opcode_e  opcode;
        op_e      op;
        reg_num_t rn;
        reg_num_t rd;
        shift_e   shift;
        reg_num_t rm;
    } alu_fields_t;

    typedef struct packed {
        opcode_e    opcode;
        op_e        op;
        reg_num_t   rn;
        reg_num_t   rd;
        logic [4:0] offset;
    } imm_fields_t;

    typedef struct packed {
        opcode_e    opcode;
        op_e        op;
        cond_e      cond;
        logic [7:0] offset;
    } branch_fields_t;

    typedef union packed {
        alu_fields_t    alu;
        imm_fields_t    imm;
        branch_fields_t branch;
    } instr_u;

endpackage
